// ==== hba_system.f ====
verilog/hba_pkg.sv
verilog/hba_cmd_parser.sv
verilog/hba_bus_master.sv
verilog/hba_basicio.sv
verilog/hba_gpio.sv
verilog/hba_rsp_sender.sv
verilog/hba_system.sv
tests/hba_system_props.sv
tests/hba_system_tb.sv

// ==== Makefile ====
# Verilator build and run of the hba_system testbench

TOP := hba_system_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench, log in sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): hba_system.f verilog/*.sv tests/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f hba_system.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "TEST OK" sim.log; then echo "simulation stopped before its end"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== tests/hba_system_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hba_system_tb;

    typedef enum logic {op_read, op_write} op_t;

    typedef struct packed {
        op_t                kind;
        hba_pkg::slot_t     slot;
        hba_pkg::reg_addr_t offset;
        hba_pkg::byte_t     data;
        hba_pkg::byte_t     button;
        hba_pkg::gpio_t     gpio_in;
        hba_pkg::byte_t     expected; // ignored for writes
    } step_t;

    logic           clk = 1'b0;
    logic           arst_n = 1'b0;
    logic           cmd_valid = 1'b0;
    hba_pkg::byte_t cmd_data = '0;
    logic           cmd_credit;
    logic           rsp_valid;
    hba_pkg::byte_t rsp_data;
    logic           rsp_credit = 1'b0;
    hba_pkg::byte_t led;
    hba_pkg::byte_t button = '0;
    hba_pkg::gpio_t gpio_oe;
    hba_pkg::gpio_t gpio_out;
    hba_pkg::gpio_t gpio_in = '0;

    step_t          steps[$];
    hba_pkg::byte_t rsp_q[$];          // bytes seen by the host
    integer         seed = 32'hff8;
    int             wait_limit = 300;  // cycles per wait
    int             cmd_sent = 0;
    int             cmd_back = 0;      // cmd_credit pulses seen
    int             rsp_seen = 0;
    int             rsp_given = 0;     // rsp_credit pulses driven
    bit             hold_credits = 1'b0;
    bit             rand_delay = 1'b0;
    bit             aborted = 1'b0;
    int             value_errors = 0;
    int             other_errors = 0;
    hba_pkg::byte_t model_led = '0;    // port state per the register map
    hba_pkg::gpio_t model_oe = '0;
    hba_pkg::gpio_t model_out = '0;

    hba_system hba_system_i (
        .clk, .arst_n, .cmd_valid, .cmd_data, .cmd_credit,
        .rsp_valid, .rsp_data, .rsp_credit,
        .led, .button, .gpio_oe, .gpio_out, .gpio_in
    );

    initial begin
        forever #50 clk = ~clk;
    end

    // host side monitor on the rising edge
    always @(posedge clk) begin
        if (cmd_credit) cmd_back++;
        if (cmd_back > cmd_sent) begin
            $display("parser returned more command credits than bytes were sent");
            other_errors++;
        end
        if (rsp_valid) begin
            rsp_q.push_back(rsp_data);
            rsp_seen++;
            if (rsp_seen > hba_pkg::RSP_CREDITS + rsp_given) begin
                $display("response byte %0d was sent without a host credit", rsp_seen);
                other_errors++;
            end
        end
    end

    // one host credit pulse per received byte
    always begin : credit_return
        int gap;
        @(negedge clk);
        rsp_credit = 1'b0;
        if (!hold_credits && rsp_given < rsp_seen) begin
            gap = rand_delay ? $unsigned($random(seed)) % 4 : 0;
            repeat (gap) @(negedge clk);
            rsp_credit = 1'b1;
            rsp_given++;
        end
    end

    task automatic check_byte(input string what, input hba_pkg::byte_t got,
                              input hba_pkg::byte_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_gpio(input string what, input hba_pkg::gpio_t got,
                              input hba_pkg::gpio_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    function automatic void add_step(input op_t kind, input hba_pkg::slot_t slot,
                                     input hba_pkg::reg_addr_t off, input hba_pkg::byte_t data,
                                     input hba_pkg::byte_t btn, input hba_pkg::gpio_t gin,
                                     input hba_pkg::byte_t exp);
        steps.push_back('{kind, slot, off, data, btn, gin, exp});
    endfunction

    // register map model of the port state
    function automatic void apply_write(input hba_pkg::slot_t slot,
                                        input hba_pkg::reg_addr_t off,
                                        input hba_pkg::byte_t data);
        if (slot == hba_pkg::SLOT_BASICIO && off == hba_pkg::REG_LED) model_led = data;
        if (slot == hba_pkg::SLOT_GPIO && off == hba_pkg::REG_GPIO_OE) model_oe = data[3:0];
        if (slot == hba_pkg::SLOT_GPIO && off == hba_pkg::REG_GPIO_OUT) model_out = data[3:0];
    endfunction

    function automatic hba_pkg::byte_t expected_read(input hba_pkg::slot_t slot,
                                                     input hba_pkg::reg_addr_t off);
        expected_read = '0; // unmapped slot or offset
        if (slot == hba_pkg::SLOT_BASICIO) begin
            if (off == hba_pkg::REG_LED) expected_read = model_led;
            if (off == hba_pkg::REG_BUTTON) expected_read = button;
        end
        if (slot == hba_pkg::SLOT_GPIO) begin
            if (off == hba_pkg::REG_GPIO_OE) expected_read = {4'h0, model_oe};
            if (off == hba_pkg::REG_GPIO_OUT) expected_read = {4'h0, model_out};
            if (off == hba_pkg::REG_GPIO_IN) expected_read = {4'h0, gpio_in};
        end
    endfunction

    // one byte per cycle while a command credit is held
    task automatic send_byte(input hba_pkg::byte_t b);
        int waited;
        waited = 0;
        while (!aborted && cmd_sent - cmd_back >= hba_pkg::CMD_CREDITS) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: no command credit came back at %0d ns", $time);
                other_errors++;
                aborted = 1'b1;
            end
        end
        if (!aborted) begin
            cmd_valid = 1'b1;
            cmd_data  = b;
            cmd_sent++;
            @(negedge clk);
            cmd_valid = 1'b0;
        end
    endtask

    task automatic send_cmd(input bit write, input hba_pkg::slot_t slot,
                            input hba_pkg::reg_addr_t off, input hba_pkg::byte_t data);
        send_byte({write, slot, off}); // write flag, slot, offset
        if (write) send_byte(data);
    endtask

    task automatic wait_responses(input int n);
        int waited;
        waited = 0;
        while (!aborted && rsp_q.size() < n) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: only %0d of %0d response bytes arrived", rsp_q.size(), n);
                other_errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic wait_cmd_idle();
        int waited;
        waited = 0;
        while (!aborted && cmd_back != cmd_sent) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: %0d command credits never returned", cmd_sent - cmd_back);
                other_errors++;
                aborted = 1'b1;
            end
        end
    endtask

    // host owes no response credit
    task automatic wait_rsp_credits();
        int waited;
        waited = 0;
        while (!aborted && rsp_given != rsp_seen) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: %0d response credits were never returned",
                         rsp_seen - rsp_given);
                other_errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic check_ports();
        check_byte("led", led, model_led);
        check_gpio("gpio_oe", gpio_oe, model_oe);
        check_gpio("gpio_out", gpio_out, model_out);
    endtask

    task automatic run_step(input step_t s);
        hba_pkg::byte_t got;
        button  = s.button;
        gpio_in = s.gpio_in;
        repeat (3) @(negedge clk); // through the two-flop synchronizers
        send_cmd(s.kind == op_write, s.slot, s.offset, s.data);
        if (s.kind == op_write) begin
            apply_write(s.slot, s.offset, s.data);
            repeat (4) @(negedge clk); // register updated within four cycles
        end else begin
            wait_responses(1);
            if (!aborted) begin
                got = rsp_q.pop_front();
                check_byte($sformatf("read slot %0d reg %0d", s.slot, s.offset), got, s.expected);
            end
        end
        wait_cmd_idle();
        check_ports();
    endtask

    // reads back to back while the host keeps its credits
    task automatic run_backpressure();
        hba_pkg::byte_t hdrs[8];
        hba_pkg::byte_t exp_q[$];
        hdrs = '{8'h10, 8'h11, 8'h20, 8'h21, 8'h22, 8'h30, 8'h17, 8'h10};
        wait_rsp_credits(); // sender starts with its full host credit
        hold_credits = 1'b1;
        for (int i = 0; i < 8; i++) begin
            send_byte(hdrs[i]);
            exp_q.push_back(expected_read(hdrs[i][6:4], hdrs[i][3:0]));
        end
        wait_responses(hba_pkg::RSP_CREDITS);
        repeat (20) @(negedge clk); // sender has to stay stalled
        if (!aborted && rsp_q.size() != hba_pkg::RSP_CREDITS) begin
            $display("%0d response bytes arrived against %0d host credits",
                     rsp_q.size(), hba_pkg::RSP_CREDITS);
            other_errors++;
        end
        hold_credits = 1'b0;
        rand_delay   = 1'b1; // drain with uneven credit gaps
        wait_responses(8);
        for (int i = 0; i < 8 && !aborted; i++) begin
            check_byte($sformatf("stalled read %0d", i), rsp_q.pop_front(), exp_q[i]);
        end
        rand_delay = 1'b0;
    endtask

    initial begin
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        check_ports(); // reset values

        // kind, slot, offset, data, button, gpio_in, expected read
        add_step(op_read,  3'd1, 4'd0, 8'h00, 8'h3c, 4'h9, 8'h00); // led after reset
        add_step(op_read,  3'd1, 4'd1, 8'h00, 8'h3c, 4'h9, 8'h3c);
        add_step(op_read,  3'd2, 4'd0, 8'h00, 8'h3c, 4'h9, 8'h00);
        add_step(op_read,  3'd2, 4'd1, 8'h00, 8'h3c, 4'h9, 8'h00);
        add_step(op_read,  3'd2, 4'd2, 8'h00, 8'h3c, 4'h9, 8'h09);
        add_step(op_write, 3'd1, 4'd0, 8'ha5, 8'h3c, 4'h9, 8'h00);
        add_step(op_read,  3'd1, 4'd0, 8'h00, 8'h3c, 4'h9, 8'ha5);
        add_step(op_write, 3'd2, 4'd0, 8'hf6, 8'h3c, 4'h9, 8'h00); // high nibble dropped
        add_step(op_write, 3'd2, 4'd1, 8'h3b, 8'h3c, 4'h9, 8'h00);
        add_step(op_read,  3'd2, 4'd0, 8'h00, 8'h3c, 4'h9, 8'h06);
        add_step(op_read,  3'd2, 4'd1, 8'h00, 8'h3c, 4'h9, 8'h0b);
        add_step(op_read,  3'd2, 4'd2, 8'h00, 8'h3c, 4'h5, 8'h05);
        add_step(op_read,  3'd1, 4'd1, 8'h00, 8'hc3, 4'h5, 8'hc3);
        add_step(op_read,  3'd5, 4'd0, 8'h00, 8'hc3, 4'h5, 8'h00); // unmapped slot
        add_step(op_read,  3'd1, 4'd7, 8'h00, 8'hc3, 4'h5, 8'h00); // unmapped offset
        add_step(op_read,  3'd2, 4'd9, 8'h00, 8'hc3, 4'h5, 8'h00);
        add_step(op_write, 3'd0, 4'd0, 8'hff, 8'hc3, 4'h5, 8'h00); // no port moves
        add_step(op_write, 3'd2, 4'd2, 8'h0f, 8'hc3, 4'h5, 8'h00); // input reg ignores it
        add_step(op_write, 3'd1, 4'd3, 8'h77, 8'hc3, 4'h5, 8'h00);
        add_step(op_write, 3'd1, 4'd0, 8'h5a, 8'hc3, 4'ha, 8'h00);
        add_step(op_read,  3'd1, 4'd0, 8'h00, 8'hc3, 4'ha, 8'h5a);
        add_step(op_read,  3'd2, 4'd2, 8'h00, 8'hc3, 4'ha, 8'h0a);

        foreach (steps[i]) begin
            if (!aborted) run_step(steps[i]);
        end
        if (!aborted) run_backpressure();
        wait_cmd_idle(); // every command credit back at the host

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0 && !aborted) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/hba_system_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module hba_system_props (
    input wire                            clk,
    input wire                            arst_n,
    input wire                            bus_wr,
    input wire                            bus_rd,
    input wire [hba_pkg::RSP_CNT_W-1:0]   rsp_cred
);

    // credits only come back for entries that were pushed
    cred_bound: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_cred <= hba_pkg::RSP_FIFO_DEPTH)
        else $error("response credit counter above the sender depth");

    // one strobe kind per cycle and none while read data is on its way
    strobe_excl: assert property (@(posedge clk) disable iff (!arst_n)
        (bus_wr || bus_rd) |-> !(bus_wr && bus_rd) && !$past(bus_rd) && !$past(bus_rd, 2))
        else $error("slot bus strobe overlaps another strobe or a pending read");

    strobe_rst: assert property (@(posedge clk) !arst_n |-> (!bus_wr && !bus_rd))
        else $error("slot bus strobe active during reset");

endmodule

// attached to the bus master by signal name
bind hba_bus_master hba_system_props hba_system_props_i (
    .clk, .arst_n, .bus_wr, .bus_rd, .rsp_cred
);

`default_nettype wire

// ==== verilog/hba_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module hba_system (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 cmd_valid,
    input  wire hba_pkg::byte_t cmd_data,
    output logic                cmd_credit,
    output logic                rsp_valid,
    output hba_pkg::byte_t      rsp_data,
    input  wire                 rsp_credit,
    output hba_pkg::byte_t      led,
    input  wire hba_pkg::byte_t button,
    output hba_pkg::gpio_t      gpio_oe,
    output hba_pkg::gpio_t      gpio_out,
    input  wire hba_pkg::gpio_t gpio_in
);

    // parser to bus master
    logic               req_valid;
    logic               req_write;
    hba_pkg::slot_t     req_slot;
    hba_pkg::reg_addr_t req_addr;
    hba_pkg::byte_t     req_wdata;
    logic               req_ready;

    // slot bus
    logic               sel_basicio;
    logic               sel_gpio;
    logic               bus_wr;
    logic               bus_rd;
    hba_pkg::reg_addr_t bus_addr;
    hba_pkg::byte_t     bus_wdata;
    hba_pkg::byte_t     basicio_rdata;
    hba_pkg::byte_t     gpio_rdata;

    // bus master to sender
    logic               rsp_push;
    hba_pkg::byte_t     rsp_push_data;
    logic               rsp_pop_credit;

    hba_cmd_parser hba_cmd_parser_i (
        .clk, .arst_n, .cmd_valid, .cmd_data, .cmd_credit,
        .req_valid, .req_write, .req_slot, .req_addr, .req_wdata, .req_ready
    );

    hba_bus_master hba_bus_master_i (
        .clk, .arst_n,
        .req_valid, .req_write, .req_slot, .req_addr, .req_wdata, .req_ready,
        .sel_basicio, .sel_gpio, .bus_wr, .bus_rd, .bus_addr, .bus_wdata,
        .basicio_rdata, .gpio_rdata,
        .rsp_push, .rsp_push_data, .rsp_pop_credit
    );

    // slot 1
    hba_basicio hba_basicio_i (
        .clk, .arst_n, .sel(sel_basicio), .bus_wr, .bus_rd, .bus_addr, .bus_wdata,
        .rdata(basicio_rdata), .led, .button
    );

    // slot 2, pad tristate control stays outside
    hba_gpio hba_gpio_i (
        .clk, .arst_n, .sel(sel_gpio), .bus_wr, .bus_rd, .bus_addr, .bus_wdata,
        .rdata(gpio_rdata), .gpio_oe, .gpio_out, .gpio_in
    );

    hba_rsp_sender hba_rsp_sender_i (
        .clk, .arst_n, .rsp_push, .rsp_push_data, .rsp_pop_credit,
        .rsp_valid, .rsp_data, .rsp_credit
    );

endmodule

`default_nettype wire

// ==== verilog/hba_rsp_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

module hba_rsp_sender (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 rsp_push,
    input  wire hba_pkg::byte_t rsp_push_data,
    output logic                rsp_pop_credit,
    output logic                rsp_valid,
    output hba_pkg::byte_t      rsp_data,
    input  wire                 rsp_credit
);

    hba_pkg::byte_t mem [hba_pkg::RSP_FIFO_DEPTH];
    logic [hba_pkg::RSP_PTR_W-1:0]   wr_ptr;
    logic [hba_pkg::RSP_PTR_W-1:0]   rd_ptr;
    logic [hba_pkg::RSP_CNT_W-1:0]   count;
    logic [hba_pkg::HOST_CRED_W-1:0] host_cred; // free slots at the host
    logic                            send;

    // head goes out only when the host has room
    assign send = (count != '0) && (host_cred != '0);

    always_ff @(posedge clk) begin
        if (rsp_push) mem[wr_ptr] <= rsp_push_data;
        if (send)     rsp_data    <= mem[rd_ptr];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            host_cred      <= hba_pkg::RSP_CREDITS[hba_pkg::HOST_CRED_W-1:0];
            rsp_valid      <= 1'b0;
            rsp_pop_credit <= 1'b0;
        end else begin
            rsp_valid      <= send;
            rsp_pop_credit <= send; // entry freed, tell the bus master
            if (rsp_push) wr_ptr <= wr_ptr + 1'b1;
            if (send)     rd_ptr <= rd_ptr + 1'b1;
            case ({rsp_push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            case ({send, rsp_credit})
                2'b10:   host_cred <= host_cred - 1'b1;
                2'b01:   host_cred <= host_cred + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hba_gpio.sv ====
`timescale 1ns/1ps
`default_nettype none

module hba_gpio (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     sel,
    input  wire                     bus_wr,
    input  wire                     bus_rd,
    input  wire hba_pkg::reg_addr_t bus_addr,
    input  wire hba_pkg::byte_t     bus_wdata,
    output hba_pkg::byte_t          rdata,
    output hba_pkg::gpio_t          gpio_oe,
    output hba_pkg::gpio_t          gpio_out,
    input  wire hba_pkg::gpio_t     gpio_in
);

    hba_pkg::gpio_t in_meta;
    hba_pkg::gpio_t in_sync;  // pins after two flops
    hba_pkg::gpio_t rd_mux;
    logic           wr_en;

    assign wr_en = sel && bus_wr;

    always_comb begin
        case (bus_addr)
            hba_pkg::REG_GPIO_OE:  rd_mux = gpio_oe;
            hba_pkg::REG_GPIO_OUT: rd_mux = gpio_out;
            hba_pkg::REG_GPIO_IN:  rd_mux = in_sync;
            default:               rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_oe  <= '0; // all pins input
            gpio_out <= '0;
            in_meta  <= '0;
            in_sync  <= '0;
            rdata    <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
            // only low nibble of the bus byte is kept
            if (wr_en && bus_addr == hba_pkg::REG_GPIO_OE) begin
                gpio_oe <= bus_wdata[hba_pkg::GPIO_W-1:0];
            end
            if (wr_en && bus_addr == hba_pkg::REG_GPIO_OUT) begin
                gpio_out <= bus_wdata[hba_pkg::GPIO_W-1:0];
            end
            if (sel && bus_rd) begin
                rdata <= {{(hba_pkg::BYTE_W-hba_pkg::GPIO_W){1'b0}}, rd_mux};
            end else begin
                rdata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hba_basicio.sv ====
`timescale 1ns/1ps
`default_nettype none

module hba_basicio (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     sel,
    input  wire                     bus_wr,
    input  wire                     bus_rd,
    input  wire hba_pkg::reg_addr_t bus_addr,
    input  wire hba_pkg::byte_t     bus_wdata,
    output hba_pkg::byte_t          rdata,
    output hba_pkg::byte_t          led,
    input  wire hba_pkg::byte_t     button
);

    hba_pkg::byte_t btn_meta; // first sync stage
    hba_pkg::byte_t btn_sync;
    hba_pkg::byte_t rd_mux;

    always_comb begin
        case (bus_addr)
            hba_pkg::REG_LED:    rd_mux = led;
            hba_pkg::REG_BUTTON: rd_mux = btn_sync;
            default:             rd_mux = '0; // unused offsets
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led      <= '0;
            btn_meta <= '0;
            btn_sync <= '0;
            rdata    <= '0;
        end else begin
            btn_meta <= button;
            btn_sync <= btn_meta;
            if (sel && bus_wr && bus_addr == hba_pkg::REG_LED) led <= bus_wdata;
            rdata <= (sel && bus_rd) ? rd_mux : '0; // valid the cycle after rd
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hba_bus_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module hba_bus_master (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     req_valid,
    input  wire                     req_write,
    input  wire hba_pkg::slot_t     req_slot,
    input  wire hba_pkg::reg_addr_t req_addr,
    input  wire hba_pkg::byte_t     req_wdata,
    output logic                    req_ready,
    output logic                    sel_basicio,
    output logic                    sel_gpio,
    output logic                    bus_wr,
    output logic                    bus_rd,
    output hba_pkg::reg_addr_t      bus_addr,
    output hba_pkg::byte_t          bus_wdata,
    input  wire hba_pkg::byte_t     basicio_rdata,
    input  wire hba_pkg::byte_t     gpio_rdata,
    output logic                    rsp_push,
    output hba_pkg::byte_t          rsp_push_data,
    input  wire                     rsp_pop_credit
);

    logic [hba_pkg::RSP_CNT_W-1:0] rsp_cred; // free sender entries
    logic req_fire;
    logic hit_basicio;
    logic hit_gpio;
    logic rd_pend;      // read data arrives this cycle
    logic rd_basicio_q; // which slot the pending read went to
    logic rd_gpio_q;

    // slot decode lives here only
    assign hit_basicio = (req_slot == hba_pkg::SLOT_BASICIO);
    assign hit_gpio    = (req_slot == hba_pkg::SLOT_GPIO);

    // one read in flight at a time, reads need a free sender entry
    assign req_ready = !bus_rd && !rd_pend && (req_write || rsp_cred != '0);
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_basicio  <= 1'b0;
            sel_gpio     <= 1'b0;
            bus_wr       <= 1'b0;
            bus_rd       <= 1'b0;
            rd_pend      <= 1'b0;
            rd_basicio_q <= 1'b0;
            rd_gpio_q    <= 1'b0;
            rsp_cred     <= hba_pkg::RSP_FIFO_DEPTH[hba_pkg::RSP_CNT_W-1:0];
        end else begin
            // single strobe cycle per request
            bus_wr       <= req_fire && req_write;
            bus_rd       <= req_fire && !req_write;
            sel_basicio  <= req_fire && hit_basicio;
            sel_gpio     <= req_fire && hit_gpio;
            rd_pend      <= bus_rd;
            rd_basicio_q <= bus_rd && sel_basicio;
            rd_gpio_q    <= bus_rd && sel_gpio;
            case ({rsp_push, rsp_pop_credit})
                2'b10:   rsp_cred <= rsp_cred - 1'b1;
                2'b01:   rsp_cred <= rsp_cred + 1'b1;
                default: ; // push and return cancel out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            bus_addr  <= req_addr;
            bus_wdata <= req_wdata;
        end
    end

    // unmapped slot leaves both selects low, reads back zero
    assign rsp_push      = rd_pend;
    assign rsp_push_data = ({hba_pkg::BYTE_W{rd_basicio_q}} & basicio_rdata)
                         | ({hba_pkg::BYTE_W{rd_gpio_q}} & gpio_rdata);

endmodule

`default_nettype wire

// ==== verilog/hba_cmd_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module hba_cmd_parser (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     cmd_valid,
    input  wire hba_pkg::byte_t     cmd_data,
    output logic                    cmd_credit,
    output logic                    req_valid,
    output logic                    req_write,
    output hba_pkg::slot_t          req_slot,
    output hba_pkg::reg_addr_t      req_addr,
    output hba_pkg::byte_t          req_wdata,
    input  wire                     req_ready
);

    hba_pkg::byte_t mem [hba_pkg::CMD_CREDITS]; // command byte buffer
    logic [hba_pkg::CMD_PTR_W-1:0] wr_ptr;
    logic [hba_pkg::CMD_PTR_W-1:0] rd_ptr;
    logic [hba_pkg::CMD_CNT_W-1:0] count;      // bytes held
    hba_pkg::parse_state_t          state;
    hba_pkg::byte_t                 head;       // oldest byte
    logic                           pop;
    logic                           hdr_write;

    assign head      = mem[rd_ptr];
    assign hdr_write = head[hba_pkg::HDR_WRITE_BIT];
    assign req_valid = (state == hba_pkg::issue);

    // only pop while looking for a header or a data byte
    always_comb begin
        pop = 1'b0;
        if (state != hba_pkg::issue) begin
            pop = (count != '0);
        end
    end

    // buffer writes, host never overruns its credits
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            mem[wr_ptr] <= cmd_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
            state      <= hba_pkg::idle;
        end else begin
            cmd_credit <= pop; // one credit back per popped byte
            if (cmd_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop)       rd_ptr <= rd_ptr + 1'b1;
            case ({cmd_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            case (state)
                hba_pkg::idle: begin
                    if (pop) state <= hdr_write ? hba_pkg::wait_data : hba_pkg::issue;
                end
                hba_pkg::wait_data: begin
                    if (pop) state <= hba_pkg::issue;
                end
                default: begin
                    if (req_ready) state <= hba_pkg::idle; // request taken
                end
            endcase
        end
    end

    // request fields, loaded as bytes are popped
    always_ff @(posedge clk) begin
        if (pop && state == hba_pkg::idle) begin
            req_write <= hdr_write;
            req_slot  <= head[hba_pkg::REG_ADDR_W +: hba_pkg::SLOT_W];
            req_addr  <= head[hba_pkg::REG_ADDR_W-1:0];
        end
        if (pop && state == hba_pkg::wait_data) begin
            req_wdata <= head;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hba_pkg.sv ====
`default_nettype none

package hba_pkg;

    // field widths
    localparam int BYTE_W     = 8;
    localparam int SLOT_W     = 3;
    localparam int REG_ADDR_W = 4;
    localparam int GPIO_W     = 4;

    typedef logic [BYTE_W-1:0]     byte_t;     // host and slot bus data
    typedef logic [SLOT_W-1:0]     slot_t;     // peripheral slot number
    typedef logic [REG_ADDR_W-1:0] reg_addr_t; // register offset in a slot
    typedef logic [GPIO_W-1:0]     gpio_t;     // slot 2 pin vector

    // slot map
    localparam slot_t SLOT_BASICIO = 3'd1;
    localparam slot_t SLOT_GPIO    = 3'd2;

    // basicio registers
    localparam reg_addr_t REG_LED    = 4'd0;
    localparam reg_addr_t REG_BUTTON = 4'd1;

    // gpio registers
    localparam reg_addr_t REG_GPIO_OE  = 4'd0;
    localparam reg_addr_t REG_GPIO_OUT = 4'd1;
    localparam reg_addr_t REG_GPIO_IN  = 4'd2; // read only

    localparam int CMD_CREDITS    = 4; // command buffer depth
    localparam int RSP_CREDITS    = 2; // host side response buffer
    localparam int RSP_FIFO_DEPTH = 2; // sender buffer
    localparam int HDR_WRITE_BIT  = 7;

    // counter and pointer widths
    localparam int CMD_PTR_W   = $clog2(CMD_CREDITS);
    localparam int CMD_CNT_W   = $clog2(CMD_CREDITS + 1);
    localparam int RSP_PTR_W   = $clog2(RSP_FIFO_DEPTH);
    localparam int RSP_CNT_W   = $clog2(RSP_FIFO_DEPTH + 1);
    localparam int HOST_CRED_W = $clog2(RSP_CREDITS + 1);

    typedef enum logic [1:0] {
        idle,      // waiting for a header byte
        wait_data, // write header seen, data byte next
        issue      // request held until the bus master takes it
    } parse_state_t;

endpackage

`default_nettype wire
